// File: common/gamePkg.sv
package gamePkg;

	// board geometry
	localparam int BoardSize = 8;
	localparam int CoordWidth = 3;

	// the cat always starts in the same tile
	localparam logic [CoordWidth-1:0] CatStartX = 3'd3;
	localparam logic [CoordWidth-1:0] CatStartY = 3'd3;

	// x is the tile column, y the tile row
	typedef struct packed
	{
		logic [CoordWidth-1:0] x;
		logic [CoordWidth-1:0] y;
	} cellPos_t;

	typedef enum logic [2:0]
	{
		StateStart,
		StatePlay,
		StateCatMove,
		StateLost,
		StateWon
	} gameState_t;

	// clear empties the whole board, en blocks the cell at pos
	typedef struct packed
	{
		logic en;
		logic clear;
		cellPos_t pos;
	} blockWrite_t;

	// bit order follows the cat's move order
	typedef struct packed
	{
		logic xPlus;
		logic xMinus;
		logic yPlus;
		logic yMinus;
	} openMask_t;

endpackage

// File: common/displayPkg.sv
package displayPkg;

	localparam int PixelWidth = 10;

	typedef struct packed
	{
		logic [PixelWidth-1:0] h;
		logic [PixelWidth-1:0] v;
		logic bright;
	} pixelPos_t;

	// 4 bits each for red, green, blue
	typedef logic [11:0] rgb_t;

	// tile windows start here and repeat every TilePitch pixels
	localparam int TileHStart = 222;
	localparam int TileVStart = 35;
	// pixels per tile, both ends included
	localparam int TileSpan = 51;
	localparam int TilePitch = 60;

	localparam rgb_t ColorEmpty = 12'hFFF;
	localparam rgb_t ColorBlocked = 12'h888;
	localparam rgb_t ColorCat = 12'hF80;
	// outside the visible area
	localparam rgb_t ColorBlank = 12'h00F;
	localparam rgb_t ColorGap = 12'hFFF;

	// result colours for the background
	localparam rgb_t ColorLost = 12'hF00;
	localparam rgb_t ColorWon = 12'h0F0;
	localparam rgb_t ColorNone = 12'h000;

endpackage

// File: game/boardMap.sv
`timescale 1ns/1ps

module boardMap import gamePkg::*;
(
	input logic clk,
	input logic rstN,
	input blockWrite_t blockWrite,
	input cellPos_t catPos,
	output openMask_t catOpen,
	input cellPos_t tileQuery,
	output logic tileBlocked
);

	localparam logic [CoordWidth-1:0] LastCoord = CoordWidth'(BoardSize - 1);

	// one bit per cell, row major
	logic [BoardSize*BoardSize-1:0] blocked;

	cellPos_t posXPlus;
	cellPos_t posXMinus;
	cellPos_t posYPlus;
	cellPos_t posYMinus;

	function automatic logic [2*CoordWidth-1:0] cellIndex(input cellPos_t pos);
		return {pos.y, pos.x};
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			blocked <= '0;
		end
		else if (blockWrite.clear)
		begin
			blocked <= '0;
		end
		else if (blockWrite.en)
		begin
			blocked[cellIndex(blockWrite.pos)] <= 1'b1;
		end
	end

	// neighbour coordinates wrap here, the edge checks below mask that out
	always_comb
	begin
		posXPlus = '{x: catPos.x + 3'd1, y: catPos.y};
		posXMinus = '{x: catPos.x - 3'd1, y: catPos.y};
		posYPlus = '{x: catPos.x, y: catPos.y + 3'd1};
		posYMinus = '{x: catPos.x, y: catPos.y - 3'd1};
	end

	// off the board counts as open
	assign catOpen.xPlus = (catPos.x == LastCoord) || !blocked[cellIndex(posXPlus)];
	assign catOpen.xMinus = (catPos.x == '0) || !blocked[cellIndex(posXMinus)];
	assign catOpen.yPlus = (catPos.y == LastCoord) || !blocked[cellIndex(posYPlus)];
	assign catOpen.yMinus = (catPos.y == '0) || !blocked[cellIndex(posYMinus)];

	assign tileBlocked = blocked[cellIndex(tileQuery)];

endmodule

// File: game/gameControl.sv
`timescale 1ns/1ps

module gameControl import gamePkg::*, displayPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic placeStrobe,
	input cellPos_t cursor,
	input openMask_t catOpen,
	output blockWrite_t blockWrite,
	output cellPos_t catPos,
	output rgb_t background
);

	localparam logic [CoordWidth-1:0] LastCoord = CoordWidth'(BoardSize - 1);

	gameState_t state;

	cellPos_t catStep;
	logic catEscapes;
	logic catTrapped;
	logic cursorOnCat;

	assign cursorOnCat = (cursor == catPos);

	// board writes act on the strobe edge itself so the move sees the new block
	always_comb
	begin
		blockWrite = '0;
		case (state)
			StateStart:
			begin
				blockWrite.clear = placeStrobe;
			end
			StatePlay:
			begin
				blockWrite.en = placeStrobe && !cursorOnCat;
				blockWrite.pos = cursor;
			end
			default:
			begin
				blockWrite = '0;
			end
		endcase
	end

	// first open neighbour in move order wins
	always_comb
	begin
		catStep = catPos;
		catEscapes = 1'b0;
		catTrapped = 1'b0;
		if (catOpen.xPlus)
		begin
			catEscapes = (catPos.x == LastCoord);
			catStep.x = catPos.x + 3'd1;
		end
		else if (catOpen.xMinus)
		begin
			catEscapes = (catPos.x == '0);
			catStep.x = catPos.x - 3'd1;
		end
		else if (catOpen.yPlus)
		begin
			catEscapes = (catPos.y == LastCoord);
			catStep.y = catPos.y + 3'd1;
		end
		else if (catOpen.yMinus)
		begin
			catEscapes = (catPos.y == '0);
			catStep.y = catPos.y - 3'd1;
		end
		else
		begin
			catTrapped = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= StateStart;
			catPos <= '{x: CatStartX, y: CatStartY};
			background <= ColorNone;
		end
		else
		begin
			case (state)
				StateStart:
				begin
					if (placeStrobe)
					begin
						catPos <= '{x: CatStartX, y: CatStartY};
						background <= ColorNone;
						state <= StatePlay;
					end
				end
				StatePlay:
				begin
					// a block on the cat's own cell is not a turn
					if (placeStrobe && !cursorOnCat)
					begin
						state <= StateCatMove;
					end
				end
				StateCatMove:
				begin
					if (catTrapped)
					begin
						background <= ColorWon;
						state <= StateWon;
					end
					else if (catEscapes)
					begin
						background <= ColorLost;
						state <= StateLost;
					end
					else
					begin
						catPos <= catStep;
						state <= StatePlay;
					end
				end
				StateLost, StateWon:
				begin
					// background keeps the result until the next game starts
					state <= StateStart;
				end
				default:
				begin
					state <= StateStart;
				end
			endcase
		end
	end

endmodule

// File: display/tileRenderer.sv
`timescale 1ns/1ps

module tileRenderer import gamePkg::*, displayPkg::*;
(
	input logic clk,
	input logic rstN,
	input pixelPos_t pixel,
	input cellPos_t catPos,
	output cellPos_t tileQuery,
	input logic tileBlocked,
	output rgb_t rgb
);

	// top bit flags a hit, the rest is the tile index
	logic [CoordWidth:0] colHit;
	logic [CoordWidth:0] rowHit;
	logic inTile;

	// searches the eight windows along one axis
	function automatic logic [CoordWidth:0] findTile(
		input logic [PixelWidth-1:0] coord,
		input int unsigned origin
	);
		logic [CoordWidth:0] result;
		int unsigned low;
		result = '0;
		for (int i = 0; i < BoardSize; i++)
		begin
			low = origin + i * TilePitch;
			if ((coord >= low) && (coord <= low + TileSpan - 1))
			begin
				result = {1'b1, CoordWidth'(i)};
			end
		end
		return result;
	endfunction

	assign colHit = findTile(pixel.h, TileHStart);
	assign rowHit = findTile(pixel.v, TileVStart);
	assign inTile = colHit[CoordWidth] && rowHit[CoordWidth];

	// column from h, row from v
	assign tileQuery.x = colHit[CoordWidth-1:0];
	assign tileQuery.y = rowHit[CoordWidth-1:0];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			rgb <= ColorBlank;
		end
		else if (!pixel.bright)
		begin
			rgb <= ColorBlank;
		end
		else if (!inTile)
		begin
			rgb <= ColorGap;
		end
		else if (tileQuery == catPos)
		begin
			rgb <= ColorCat;
		end
		else if (tileBlocked)
		begin
			rgb <= ColorBlocked;
		end
		else
		begin
			rgb <= ColorEmpty;
		end
	end

endmodule

// File: src/gameTop.sv
`timescale 1ns/1ps

module gameTop import gamePkg::*, displayPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic placeStrobe,
	input cellPos_t cursor,
	input pixelPos_t pixel,
	output rgb_t rgb,
	output rgb_t background
);

	blockWrite_t blockWrite;
	cellPos_t catPos;
	openMask_t catOpen;
	cellPos_t tileQuery;
	logic tileBlocked;

	gameControl gameControl0
	(
		.clk(clk),
		.rstN(rstN),
		.placeStrobe(placeStrobe),
		.cursor(cursor),
		.catOpen(catOpen),
		.blockWrite(blockWrite),
		.catPos(catPos),
		.background(background)
	);

	boardMap boardMap0
	(
		.clk(clk),
		.rstN(rstN),
		.blockWrite(blockWrite),
		.catPos(catPos),
		.catOpen(catOpen),
		.tileQuery(tileQuery),
		.tileBlocked(tileBlocked)
	);

	// renderer reads the board through its own query port
	tileRenderer tileRenderer0
	(
		.clk(clk),
		.rstN(rstN),
		.pixel(pixel),
		.catPos(catPos),
		.tileQuery(tileQuery),
		.tileBlocked(tileBlocked),
		.rgb(rgb)
	);

endmodule

// File: bench/gameTb.sv
`timescale 1ns/1ps

module gameTb import gamePkg::*, displayPkg::*;
();

	localparam int ClkPeriod = 4;
	localparam int ResetCycles = 3;
	localparam int StartPixels = 200;
	localparam int RandomTurns = 24;
	// strobe, two background checks, five pixels and a drain, plus a possible restart
	localparam int TurnCycles = 16;
	localparam int BudgetCycles = 2 * ResetCycles + StartPixels + RandomTurns * TurnCycles
		+ 12 * TurnCycles + BoardSize * BoardSize + 200;

	typedef struct packed
	{
		logic escape;
		logic trapped;
		cellPos_t pos;
	} moveResult_t;

	logic clk;
	logic rstN;
	logic placeStrobe;
	cellPos_t cursor;
	pixelPos_t pixel;
	rgb_t rgb;
	rgb_t background;

	// board model indexed [x][y]
	bit modelBlocked [BoardSize][BoardSize];
	cellPos_t modelCat;
	bit gameOver;
	logic [31:0] rngState = 32'd1637;
	logic pixelCheck;
	logic pendValid = 1'b0;
	rgb_t pendColor;
	string testName;
	int testChecks;
	int testErrors;
	int checkCount = 0;
	int errorCount = 0;
	int testCount = 0;

	gameTop dut0
	(
		.clk(clk),
		.rstN(rstN),
		.placeStrobe(placeStrobe),
		.cursor(cursor),
		.pixel(pixel),
		.rgb(rgb),
		.background(background)
	);

	initial clk = 1'b0;
	always #(ClkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function automatic cellPos_t randomCell();
		logic [31:0] r;
		cellPos_t c;
		r = nextRandom();
		c.x = r[2:0];
		c.y = r[5:3];
		return c;
	endfunction

	// spans roughly a full 800 by 525 frame and blanks one pixel in eight
	function automatic pixelPos_t randomPixel();
		logic [31:0] r;
		pixelPos_t p;
		r = nextRandom();
		p.h = PixelWidth'(r % 800);
		p.v = PixelWidth'((r >> 10) % 525);
		p.bright = ((r >> 20) % 8) != 0;
		return p;
	endfunction

	function automatic pixelPos_t tileCenter(input cellPos_t c);
		pixelPos_t p;
		p.h = PixelWidth'(TileHStart + c.x * TilePitch + TileSpan / 2);
		p.v = PixelWidth'(TileVStart + c.y * TilePitch + TileSpan / 2);
		p.bright = 1'b1;
		return p;
	endfunction

	// -1 in a gap or off the grid
	function automatic int tileIndex(input int coord, input int origin);
		int offset;
		offset = coord - origin;
		if (offset < 0 || offset / TilePitch >= BoardSize || offset % TilePitch >= TileSpan)
			return -1;
		return offset / TilePitch;
	endfunction

	function automatic rgb_t expectedColor(input pixelPos_t p);
		int col;
		int row;
		rgb_t color;
		col = tileIndex(int'(p.h), TileHStart);
		row = tileIndex(int'(p.v), TileVStart);
		if (!p.bright)
			color = ColorBlank;
		else if (col < 0 || row < 0)
			color = ColorGap;
		else if (col == int'(modelCat.x) && row == int'(modelCat.y))
			color = ColorCat;
		else if (modelBlocked[col][row])
			color = ColorBlocked;
		else
			color = ColorEmpty;
		return color;
	endfunction

	// tries neighbours in move order and treats a step off the grid as an escape
	function automatic moveResult_t expectedMove(input cellPos_t cat);
		int stepX [4];
		int stepY [4];
		int nx;
		int ny;
		bit done;
		moveResult_t res;
		stepX = '{1, -1, 0, 0};
		stepY = '{0, 0, 1, -1};
		res.escape = 1'b0;
		res.trapped = 1'b1;
		res.pos = cat;
		done = 1'b0;
		for (int k = 0; k < 4 && !done; k++)
		begin
			nx = int'(cat.x) + stepX[k];
			ny = int'(cat.y) + stepY[k];
			if (nx < 0 || nx >= BoardSize || ny < 0 || ny >= BoardSize)
			begin
				res.escape = 1'b1;
				res.trapped = 1'b0;
				done = 1'b1;
			end
			else if (!modelBlocked[nx][ny])
			begin
				res.trapped = 1'b0;
				res.pos.x = nx[2:0];
				res.pos.y = ny[2:0];
				done = 1'b1;
			end
		end
		return res;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		testChecks++;
		if (actual !== expected)
		begin
			testErrors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic endTest();
		$display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
		checkCount += testChecks;
		errorCount += testErrors;
		testCount++;
	endtask

	task automatic clearModel();
		for (int x = 0; x < BoardSize; x++)
			for (int y = 0; y < BoardSize; y++)
				modelBlocked[x][y] = 1'b0;
		modelCat.x = CatStartX;
		modelCat.y = CatStartY;
		gameOver = 1'b0;
	endtask

	// the renderer registers the colour of the pixel it sees at this edge
	always @(posedge clk)
	begin
		pendColor <= expectedColor(pixel);
		pendValid <= pixelCheck;
	end

	always @(negedge clk)
	begin
		if (pendValid)
			checkValue(testName, pendColor, rgb);
	end

	task automatic checkPixel(input pixelPos_t p);
		@(posedge clk);
		pixel <= p;
		pixelCheck <= 1'b1;
	endtask

	task automatic drainChecks();
		@(posedge clk);
		pixelCheck <= 1'b0;
		@(negedge clk);
		#1;
	endtask

	task automatic applyReset();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (ResetCycles) @(posedge clk);
		rstN <= 1'b1;
		clearModel();
	endtask

	task automatic startGame();
		@(posedge clk);
		placeStrobe <= 1'b1;
		cursor <= randomCell();
		@(posedge clk);
		placeStrobe <= 1'b0;
		clearModel();
		@(negedge clk);
		checkValue(testName, ColorNone, background);
	endtask

	task automatic playTurn(input cellPos_t c);
		moveResult_t move;
		cellPos_t oldCat;
		logic isTurn;
		rgb_t resultColor;
		oldCat = modelCat;
		isTurn = (c != modelCat);
		move = '0;
		resultColor = ColorNone;
		@(posedge clk);
		placeStrobe <= 1'b1;
		cursor <= c;
		@(posedge clk);
		placeStrobe <= 1'b0;
		if (isTurn)
		begin
			modelBlocked[c.x][c.y] = 1'b1;
			move = expectedMove(modelCat);
		end
		if (move.escape)
			resultColor = ColorLost;
		else if (move.trapped)
			resultColor = ColorWon;
		// result lands one edge after the block write
		@(negedge clk);
		checkValue(testName, ColorNone, background);
		@(negedge clk);
		checkValue(testName, resultColor, background);
		if (isTurn && !move.escape && !move.trapped)
			modelCat = move.pos;
		gameOver = move.escape || move.trapped;
		checkPixel(tileCenter(c));
		checkPixel(tileCenter(oldCat));
		checkPixel(tileCenter(modelCat));
		checkPixel(randomPixel());
		checkPixel(randomPixel());
		drainChecks();
	endtask

	initial
	begin
		pixelPos_t p;
		cellPos_t c;
		cellPos_t trapPath [5];
		rstN = 1'b0;
		placeStrobe = 1'b0;
		cursor = '0;
		pixel = '0;
		pixelCheck = 1'b0;
		clearModel();
		repeat (ResetCycles) @(posedge clk);
		rstN <= 1'b1;

		beginTest("reset");
		@(negedge clk);
		checkValue(testName, ColorNone, background);
		p = tileCenter(modelCat);
		checkPixel(p);
		p.bright = 1'b0;
		checkPixel(p);
		drainChecks();
		endTest();

		beginTest("empty board");
		startGame();
		p = tileCenter(modelCat);
		checkPixel(p);
		// edge pixels of the cat's tile and the gap pixels just past its right and top edges
		p.h = PixelWidth'(TileHStart + int'(modelCat.x) * TilePitch + TileSpan - 1);
		checkPixel(p);
		p.h = PixelWidth'(TileHStart + int'(modelCat.x) * TilePitch + TileSpan);
		checkPixel(p);
		p = tileCenter(modelCat);
		p.v = PixelWidth'(TileVStart + int'(modelCat.y) * TilePitch);
		checkPixel(p);
		p.v = PixelWidth'(TileVStart + int'(modelCat.y) * TilePitch - 1);
		checkPixel(p);
		repeat (StartPixels) checkPixel(randomPixel());
		drainChecks();
		endTest();

		beginTest("random turns");
		for (int t = 0; t < RandomTurns; t++)
		begin
			if (gameOver)
				startGame();
			playTurn(randomCell());
		end
		endTest();

		// the cat walks x+1 from the start tile and leaves past the right edge
		beginTest("escape");
		applyReset();
		startGame();
		for (int k = 0; k < 5; k++)
		begin
			c.x = 3'd0;
			c.y = 3'(k);
			playTurn(c);
		end
		checkValue(testName, ColorLost, background);
		startGame();
		for (int k = 0; k < 5; k++)
		begin
			c.x = 3'd0;
			c.y = 3'(k);
			checkPixel(tileCenter(c));
		end
		checkPixel(tileCenter(modelCat));
		drainChecks();
		endTest();

		// octal digits give x then y and the cat ends boxed in at (5,3)
		beginTest("trap");
		trapPath = '{6'o63, 6'o54, 6'o52, 6'o00, 6'o43};
		for (int k = 0; k < 5; k++)
			playTurn(trapPath[k]);
		checkValue(testName, ColorWon, background);
		endTest();

		beginTest("block on cat");
		startGame();
		playTurn(modelCat);
		for (int x = 0; x < BoardSize; x++)
		begin
			for (int y = 0; y < BoardSize; y++)
			begin
				c.x = 3'(x);
				c.y = 3'(y);
				checkPixel(tileCenter(c));
			end
		end
		drainChecks();
		playTurn(6'o00);
		endTest();

		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		#(BudgetCycles * ClkPeriod);
		$display("timeout: the tests did not finish within %0d cycles", BudgetCycles);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: vlog.f
common/gamePkg.sv
common/displayPkg.sv
game/boardMap.sv
game/gameControl.sv
display/tileRenderer.sv
src/gameTop.sv
bench/gameTb.sv

// File: Bender.yml
package:
  name: trap_cat

sources:
  - common/gamePkg.sv
  - common/displayPkg.sv
  - game/boardMap.sv
  - game/gameControl.sv
  - display/tileRenderer.sv
  - src/gameTop.sv
  - target: test
    files:
      - bench/gameTb.sv
